// ==== source/gb_io_pkg.sv ====
// ----------------------------------------------------------
// shared definitions for the I/O and internal memory side
// address map, interrupt vectors, serial timing
// gb_addr_t union with its io and wram views
// ----------------------------------------------------------
`default_nettype none

package gb_io_pkg;

	// ----------------------------------------------------------
	// address map
	// ----------------------------------------------------------
	localparam logic [7:0] PAGE_IO   = 8'hFF;   // register page
	localparam logic [7:0] ADDR_JOYP = 8'h00;   // P1
	localparam logic [7:0] ADDR_SB   = 8'h01;   // serial data
	localparam logic [7:0] ADDR_SC   = 8'h02;   // serial control
	localparam logic [7:0] ADDR_IF   = 8'h0F;
	localparam logic [7:0] ADDR_SVBK = 8'h70;   // colour mode only
	localparam logic [7:0] ADDR_IE   = 8'hFF;

	// C000 and D000 share one 8k region, bank_sel splits them
	localparam logic [2:0] REGION_WRAM0 = 3'b110;
	localparam logic [2:0] REGION_WRAM1 = 3'b110;

	localparam int HRAM_DEPTH = 127;   // FF80..FFFE
	localparam int WRAM_BANKS = 8;     // 4k each

	// ----------------------------------------------------------
	// interrupts
	// ----------------------------------------------------------
	localparam int IRQ_COUNT  = 5;
	localparam int IRQ_VBLANK = 0;     // highest priority
	localparam int IRQ_LCD    = 1;
	localparam int IRQ_TIMER  = 2;
	localparam int IRQ_SERIAL = 3;
	localparam int IRQ_JOYPAD = 4;

	localparam logic [7:0] IRQ_VEC_BASE = 8'h40;
	localparam logic [7:0] IRQ_VEC_STEP = 8'h08;
	localparam logic [7:0] IRQ_VEC_NONE = 8'h55;   // nothing pending

	// serial timing, internal clock
	localparam int         SERIAL_BIT_CYCLES = 512;
	localparam logic [3:0] SERIAL_BITS       = 4'd8;

	localparam logic [7:0] OPEN_BUS = 8'hFF;   // unmapped reads

	// two readings of the same 16-bit cpu address
	typedef struct packed {
		logic [7:0] page;     // high byte
		logic [7:0] offset;   // register offset on the page
	} io_view_t;

	typedef struct packed {
		logic [2:0]  region;     // 8k region
		logic        bank_sel;   // 0 = C000 half, 1 = D000 half
		logic [11:0] offset;     // byte within the 4k bank
	} wram_view_t;

	typedef union packed {
		io_view_t   io;
		wram_view_t wram;
	} gb_addr_t;

endpackage

`default_nettype wire

// ==== source/io_bus_if.sv ====
// ----------------------------------------------------------
// internal register bus between decoder and targets
// address, write data, write strobe, one select per target
// ----------------------------------------------------------
`default_nettype none

interface io_bus_if import gb_io_pkg::*; ();

	gb_addr_t   addr;    // cpu address, both views
	logic [7:0] wdata;
	logic       wr;

	// selects, already qualified by mode
	logic sel_joyp;
	logic sel_sc;
	logic sel_if;
	logic sel_ie;
	logic sel_svbk;   // only high in colour mode
	logic sel_wram;   // C000..DFFF
	logic sel_hram;   // FF80..FFFE

	// decode side drives everything
	modport decoder (
		output addr,
		output wdata,
		output wr,
		output sel_joyp,
		output sel_sc,
		output sel_if,
		output sel_ie,
		output sel_svbk,
		output sel_wram,
		output sel_hram
	);

	// peripherals only listen
	modport target (
		input addr,
		input wdata,
		input wr,
		input sel_joyp,
		input sel_sc,
		input sel_if,
		input sel_ie,
		input sel_svbk,
		input sel_wram,
		input sel_hram
	);

endinterface

`default_nettype wire

// ==== source/bus_decoder.sv ====
// ----------------------------------------------------------
// cpu bus decode
// region and register selects onto the internal bus
// registered read multiplexer, open bus for holes
// ----------------------------------------------------------
`default_nettype none

module bus_decoder import gb_io_pkg::*; (
	input  logic       clk_cpu,
	input  logic       reset,
	input  logic       is_cgb,
	input  gb_addr_t   addr,
	input  logic [7:0] wdata,
	input  logic       rd,
	input  logic       wr,
	io_bus_if.decoder  bus,
	input  logic [7:0] joyp_rdata,
	input  logic [7:0] sc_rdata,
	input  logic [7:0] if_rdata,
	input  logic [7:0] ie_rdata,
	input  logic [7:0] svbk_rdata,
	input  logic [7:0] ram_rdata,
	output logic [7:0] rdata
);

	logic       on_io_page;
	logic       rd_q;        // read in flight
	logic [6:0] src_q;       // one-hot source of that read
	logic [7:0] read_data;

	assign on_io_page = (addr.io.page == PAGE_IO);

	// pass-through part of the bus
	assign bus.addr  = addr;
	assign bus.wdata = wdata;
	assign bus.wr    = wr;

	// single-offset registers on the FF page
	assign bus.sel_joyp = on_io_page && (addr.io.offset == ADDR_JOYP);
	assign bus.sel_sc   = on_io_page && (addr.io.offset == ADDR_SC);
	assign bus.sel_if   = on_io_page && (addr.io.offset == ADDR_IF);
	assign bus.sel_ie   = on_io_page && (addr.io.offset == ADDR_IE);
	assign bus.sel_svbk = on_io_page && (addr.io.offset == ADDR_SVBK) && is_cgb;

	// upper half of the page minus IE
	assign bus.sel_hram = on_io_page && addr.io.offset[7] && (addr.io.offset != ADDR_IE);

	// C000..DFFF, bank_sel picks the half
	assign bus.sel_wram = ((addr.wram.region == REGION_WRAM0) && !addr.wram.bank_sel) ||
		((addr.wram.region == REGION_WRAM1) && addr.wram.bank_sel);

	// ----------------------------------------------------------
	// read path
	// ----------------------------------------------------------

	// src_q bit map: 6 hram, 5 wram, 4 svbk, 3 ie, 2 if, 1 sc, 0 joyp
	always_comb begin
		read_data = OPEN_BUS;   // holes, SB and mono-mode SVBK
		if (src_q[0]) read_data = joyp_rdata;
		if (src_q[1]) read_data = sc_rdata;
		if (src_q[2]) read_data = if_rdata;
		if (src_q[3]) read_data = ie_rdata;
		if (src_q[4]) read_data = svbk_rdata;
		if (src_q[5] || src_q[6]) read_data = ram_rdata;   // shared sync-read port
	end

	// stage 1 latches the source while the RAMs fetch, stage 2 loads rdata
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			rd_q  <= 1'b0;
			src_q <= '0;
			rdata <= OPEN_BUS;
		end else begin
			rd_q  <= rd;
			src_q <= {bus.sel_hram, bus.sel_wram, bus.sel_svbk,
				bus.sel_ie, bus.sel_if, bus.sel_sc, bus.sel_joyp};
			if (rd_q)
				rdata <= read_data;   // holds until the next read
		end
	end

endmodule

`default_nettype wire

// ==== source/interrupt_ctrl.sv ====
// ----------------------------------------------------------
// interrupt controller
// IF and IE registers, fixed priority vector
// acknowledge clears the winning request
// ----------------------------------------------------------
`default_nettype none

module interrupt_ctrl import gb_io_pkg::*; (
	input  logic                 clk_cpu,
	input  logic                 reset,
	io_bus_if.target             bus,
	input  logic [IRQ_COUNT-1:0] irq_req,   // one-cycle pulses
	input  logic                 irq_ack,
	output logic [7:0]           if_rdata,
	output logic [7:0]           ie_rdata,
	output logic                 irq_n,
	output logic [7:0]           irq_vector
);

	logic [IRQ_COUNT-1:0] if_reg;
	logic [IRQ_COUNT-1:0] ie_reg;
	logic [IRQ_COUNT-1:0] pending;
	logic [IRQ_COUNT-1:0] ack_mask;   // lowest pending bit only
	logic [2:0]           irq_idx;

	assign pending  = if_reg & ie_reg;
	assign ack_mask = pending & (~pending + 1'b1);   // isolate lowest set bit

	// lowest bit wins, scan from the top down
	always_comb begin
		irq_idx = '0;
		for (int i = IRQ_COUNT - 1; i >= 0; i--) begin
			if (pending[i])
				irq_idx = 3'(i);
		end
	end

	assign irq_n      = ~|pending;
	assign irq_vector = irq_n ? IRQ_VEC_NONE : IRQ_VEC_BASE + IRQ_VEC_STEP * {5'd0, irq_idx};

	// unused upper bits read 1 in IF, 0 in IE
	assign if_rdata = {3'b111, if_reg};
	assign ie_rdata = {3'b000, ie_reg};

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_reg <= '0;
			ie_reg <= '0;
		end else begin
			if (bus.sel_ie && bus.wr)
				ie_reg <= bus.wdata[IRQ_COUNT-1:0];

			// write beats ack, a new event beats both
			if (bus.sel_if && bus.wr)
				if_reg <= bus.wdata[IRQ_COUNT-1:0] | irq_req;
			else if (irq_ack)
				if_reg <= (if_reg & ~ack_mask) | irq_req;
			else
				if_reg <= if_reg | irq_req;
		end
	end

endmodule

`default_nettype wire

// ==== source/joypad.sv ====
// ----------------------------------------------------------
// joypad
// P1 select bits and the 2x4 key matrix readback
// synchronizer and falling-edge press detector
// ----------------------------------------------------------
`default_nettype none

module joypad import gb_io_pkg::*; (
	input  logic       clk_cpu,
	input  logic       reset,
	io_bus_if.target   bus,
	input  logic [7:0] joystick,   // active high, one bit per key
	output logic [7:0] joyp_rdata,
	output logic       press_irq
);

	logic [1:0] p54;        // select bits, 0 = row enabled
	logic [3:0] dir_keys;   // right left up down
	logic [3:0] btn_keys;   // a b select start
	logic [3:0] lines;
	logic [3:0] sync_1;
	logic [3:0] sync_2;
	logic [3:0] lines_q;    // previous synced sample

	// active low, deselected row floats high
	assign dir_keys = ~{joystick[2], joystick[3], joystick[1], joystick[0]} | {4{p54[0]}};
	assign btn_keys = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{p54[1]}};
	assign lines    = dir_keys & btn_keys;

	assign joyp_rdata = {2'b11, p54, lines};

	// any line going 1 -> 0
	assign press_irq = |(lines_q & ~sync_2);

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			p54     <= 2'b00;
			sync_1  <= 4'hF;   // all released
			sync_2  <= 4'hF;
			lines_q <= 4'hF;
		end else begin
			if (bus.sel_joyp && bus.wr)
				p54 <= bus.wdata[5:4];
			sync_1  <= lines;
			sync_2  <= sync_1;
			lines_q <= sync_2;
		end
	end

endmodule

`default_nettype wire

// ==== source/serial_port.sv ====
// ----------------------------------------------------------
// dummy serial port
// SC register, bit-period divider and bit counter
// transfer-complete interrupt, no data shifted
// ----------------------------------------------------------
`default_nettype none

module serial_port import gb_io_pkg::*; (
	input  logic       clk_cpu,
	input  logic       reset,
	io_bus_if.target   bus,
	output logic [7:0] sc_rdata,
	output logic       serial_irq
);

	logic                                 sc_start;   // bit 7, transfer running
	logic                                 sc_clk;     // bit 0, internal clock
	logic [$clog2(SERIAL_BIT_CYCLES)-1:0] div_cnt;    // cycles left in this bit
	logic [3:0]                           bit_cnt;    // bits left
	logic                                 running;

	assign running  = sc_start && sc_clk;   // external clock never ticks here
	assign sc_rdata = {sc_start, 6'h3F, sc_clk};

	// all bits gone, fires in the cycle the start bit drops
	assign serial_irq = running && (bit_cnt == '0);

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sc_start <= 1'b0;
			sc_clk   <= 1'b0;
			div_cnt  <= '1;
			bit_cnt  <= SERIAL_BITS;
		end else if (bus.sel_sc && bus.wr) begin
			sc_start <= bus.wdata[7];
			sc_clk   <= bus.wdata[0];
			if (bus.wdata[7]) begin   // (re)start transfer
				div_cnt <= '1;   // power-of-two period, reload is all ones
				bit_cnt <= SERIAL_BITS;
			end
		end else if (running) begin
			div_cnt <= div_cnt - 1'b1;   // wraps to all ones each bit
			if (div_cnt == '0 && bit_cnt != '0)
				bit_cnt <= bit_cnt - 1'b1;
			if (bit_cnt == '0) begin   // done
				sc_start <= 1'b0;
				div_cnt  <= '1;
				bit_cnt  <= SERIAL_BITS;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/internal_ram.sv ====
// ----------------------------------------------------------
// internal memories
// 32k banked work RAM with SVBK bank register
// 127-byte high RAM, both with synchronous read
// ----------------------------------------------------------
`default_nettype none

module internal_ram import gb_io_pkg::*; (
	input  logic       clk_cpu,
	input  logic       reset,
	input  logic       is_cgb,
	io_bus_if.target   bus,
	output logic [7:0] svbk_rdata,
	output logic [7:0] ram_rdata
);

	logic [7:0]  wram [WRAM_BANKS * 4096];
	logic [7:0]  hram [HRAM_DEPTH];
	logic [2:0]  svbk_bank;   // 1..7, never 0
	logic [2:0]  cur_bank;
	logic [14:0] wram_addr;
	logic [6:0]  hram_addr;

	assign cur_bank  = is_cgb ? svbk_bank : 3'd1;   // mono is fixed at bank 1
	// C000 half is always bank 0
	assign wram_addr = {bus.addr.wram.bank_sel ? cur_bank : 3'd0, bus.addr.wram.offset};
	assign hram_addr = bus.addr.io.offset[6:0];   // FF80 -> entry 0

	assign svbk_rdata = {5'b11111, svbk_bank};

	// SVBK
	always_ff @(posedge clk_cpu) begin
		if (reset)
			svbk_bank <= 3'd1;
		else if (bus.sel_svbk && bus.wr) begin
			if (bus.wdata[2:0] == 3'd0)
				svbk_bank <= 3'd1;   // 0 maps to 1
			else
				svbk_bank <= bus.wdata[2:0];
		end
	end

	// memories, one shared read register
	always_ff @(posedge clk_cpu) begin
		if (bus.sel_wram && bus.wr)
			wram[wram_addr] <= bus.wdata;
		if (bus.sel_hram && bus.wr)
			hram[hram_addr] <= bus.wdata;

		if (bus.sel_hram)
			ram_rdata <= hram[hram_addr];
		else
			ram_rdata <= wram[wram_addr];   // old data on read-during-write
	end

endmodule

`default_nettype wire

// ==== source/gb_io_top.sv ====
// ----------------------------------------------------------
// top level of the I/O and memory side
// plain cpu bus ports, internal bus instance
// decoder, interrupt controller, joypad, serial, RAMs
// ----------------------------------------------------------
`default_nettype none

module gb_io_top import gb_io_pkg::*; (
	input  logic        clk_cpu,
	input  logic        reset,
	input  logic        is_cgb,
	input  logic [15:0] addr,
	input  logic [7:0]  wdata,
	input  logic        rd,
	input  logic        wr,
	input  logic        irq_ack,
	input  logic [7:0]  joystick,
	input  logic        vblank_irq,
	input  logic        lcd_irq,
	input  logic        timer_irq,
	output logic [7:0]  rdata,
	output logic        irq_n,
	output logic [7:0]  irq_vector
);

	logic [7:0]           joyp_rdata;
	logic [7:0]           sc_rdata;
	logic [7:0]           if_rdata;
	logic [7:0]           ie_rdata;
	logic [7:0]           svbk_rdata;
	logic [7:0]           ram_rdata;
	logic                 press_irq;
	logic                 serial_irq;
	logic [IRQ_COUNT-1:0] irq_req;

	io_bus_if bus ();

	// request lines in priority order
	assign irq_req[IRQ_VBLANK] = vblank_irq;
	assign irq_req[IRQ_LCD]    = lcd_irq;
	assign irq_req[IRQ_TIMER]  = timer_irq;
	assign irq_req[IRQ_SERIAL] = serial_irq;
	assign irq_req[IRQ_JOYPAD] = press_irq;

	bus_decoder u_decoder (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.is_cgb     (is_cgb),
		.addr       (addr),
		.wdata      (wdata),
		.rd         (rd),
		.wr         (wr),
		.bus        (bus.decoder),
		.joyp_rdata (joyp_rdata),
		.sc_rdata   (sc_rdata),
		.if_rdata   (if_rdata),
		.ie_rdata   (ie_rdata),
		.svbk_rdata (svbk_rdata),
		.ram_rdata  (ram_rdata),
		.rdata      (rdata)
	);

	interrupt_ctrl u_irq (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.bus        (bus.target),
		.irq_req    (irq_req),
		.irq_ack    (irq_ack),
		.if_rdata   (if_rdata),
		.ie_rdata   (ie_rdata),
		.irq_n      (irq_n),
		.irq_vector (irq_vector)
	);

	joypad u_joypad (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.bus        (bus.target),
		.joystick   (joystick),
		.joyp_rdata (joyp_rdata),
		.press_irq  (press_irq)
	);

	serial_port u_serial (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.bus        (bus.target),
		.sc_rdata   (sc_rdata),
		.serial_irq (serial_irq)
	);

	internal_ram u_ram (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.is_cgb     (is_cgb),
		.bus        (bus.target),
		.svbk_rdata (svbk_rdata),
		.ram_rdata  (ram_rdata)
	);

endmodule

`default_nettype wire

// ==== tests/gb_io_assertions.sv ====
// ----------------------------------------------------------
// concurrent checks on the interrupt controller
// irq_n tracks IF and IE, idle acknowledge is harmless
// IF bits only clear on acknowledge or write
// ----------------------------------------------------------
`default_nettype none

module gb_io_assertions import gb_io_pkg::*; (
	input logic                 clk_cpu,
	input logic                 reset,
	input logic [IRQ_COUNT-1:0] if_reg,
	input logic [IRQ_COUNT-1:0] ie_reg,
	input logic [IRQ_COUNT-1:0] irq_req,
	input logic                 irq_ack,
	input logic                 irq_n,
	input logic                 sel_if,
	input logic                 wr
);

	logic if_write;   // cpu write to IF this cycle

	assign if_write = sel_if && wr;

	// line low exactly when held or newly raised requests meet IE
	irq_line_follows: assert property (@(posedge clk_cpu) disable iff (reset)
		(!irq_ack && !if_write) |=>
		(irq_n == !(|(($past(if_reg) | $past(irq_req)) & ie_reg))))
		else $error("irq_n disagrees with IF and IE");

	// ack with nothing pending only lets new requests in
	idle_ack_keeps_if: assert property (@(posedge clk_cpu) disable iff (reset)
		(irq_ack && !(|(if_reg & ie_reg)) && !if_write) |=>
		(if_reg == ($past(if_reg) | $past(irq_req))))
		else $error("acknowledge with nothing pending changed IF");

	no_stray_clear: assert property (@(posedge clk_cpu) disable iff (reset)
		(!irq_ack && !if_write) |=> (($past(if_reg) & ~if_reg) == '0))
		else $error("IF bit cleared without ack or write");

endmodule

// attach to every interrupt controller instance
bind interrupt_ctrl gb_io_assertions u_irq_checks (
	.clk_cpu (clk_cpu),
	.reset   (reset),
	.if_reg  (if_reg),
	.ie_reg  (ie_reg),
	.irq_req (irq_req),
	.irq_ack (irq_ack),
	.irq_n   (irq_n),
	.sel_if  (bus.sel_if),
	.wr      (bus.wr)
);

`default_nettype wire

// ==== tests/tb_gb_io.sv ====
// ----------------------------------------------------------
// testbench for the I/O and internal memory top level
// table of bus accesses, key states, irq pulses and waits
// applied in one loop, cycle watchdog, seeded random data
// ----------------------------------------------------------
`default_nettype none

module tb_gb_io;

	// table entry kinds
	localparam logic [2:0] K_WRITE = 3'd0;   // addr, data
	localparam logic [2:0] K_READ  = 3'd1;   // addr, expected rdata
	localparam logic [2:0] K_KEYS  = 3'd2;   // joystick = data
	localparam logic [2:0] K_MODE  = 3'd3;   // is_cgb = data[0]
	localparam logic [2:0] K_RAISE = 3'd4;   // pulse timer/lcd/vblank from data[2:0]
	localparam logic [2:0] K_ACK   = 3'd5;   // vector check, then ack plus data[2:0] pulses
	localparam logic [2:0] K_WAIT  = 3'd6;   // data cycles, then irq_n check

	typedef struct packed {
		logic [2:0]  kind;
		logic [15:0] addr;
		logic [15:0] data;
		logic [7:0]  expected;
	} entry_t;

	logic        clk_cpu;
	logic        reset;
	logic        is_cgb;
	logic [15:0] addr;
	logic [7:0]  wdata;
	logic        rd;
	logic        wr;
	logic        irq_ack;
	logic [7:0]  joystick;
	logic        vblank_irq;
	logic        lcd_irq;
	logic        timer_irq;
	logic [7:0]  rdata;
	logic        irq_n;
	logic [7:0]  irq_vector;

	entry_t table_q[$];
	int     cycle_count = 0;
	int     cycle_limit = 0;
	int     err_count   = 0;

	gb_io_top dut (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.is_cgb     (is_cgb),
		.addr       (addr),
		.wdata      (wdata),
		.rd         (rd),
		.wr         (wr),
		.irq_ack    (irq_ack),
		.joystick   (joystick),
		.vblank_irq (vblank_irq),
		.lcd_irq    (lcd_irq),
		.timer_irq  (timer_irq),
		.rdata      (rdata),
		.irq_n      (irq_n),
		.irq_vector (irq_vector)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #20 clk_cpu = ~clk_cpu;
	end

	// watchdog
	always @(posedge clk_cpu) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout after %0d cycles, the table did not finish", cycle_count);
			$display(">>> FAIL");
			$fatal(1, "run aborted by watchdog");
		end
	end

	task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("mismatch %s: got %02h, expected %02h", what, got, exp);
			$display(">>> FAIL");
			$fatal(1, "stopped at first error");
		end
	endtask

	// inputs change 2 units after the edge, outputs are settled by then
	task automatic tick();
		@(posedge clk_cpu);
		#2;
	endtask

	task automatic add_entry(input logic [2:0] kind, input logic [15:0] a,
		input logic [15:0] d, input logic [7:0] e);
		entry_t ent;
		ent.kind     = kind;
		ent.addr     = a;
		ent.data     = d;
		ent.expected = e;
		table_q.push_back(ent);
	endtask

	task automatic queue_write(input logic [15:0] a, input logic [7:0] d);
		add_entry(K_WRITE, a, {8'h00, d}, 8'h00);
	endtask

	task automatic expect_read(input logic [15:0] a, input logic [7:0] e);
		add_entry(K_READ, a, 16'h0000, e);
	endtask

	task automatic run_entry(input entry_t ent);
		case (ent.kind)
			K_WRITE: begin
				addr  = ent.addr;
				wdata = ent.data[7:0];
				wr    = 1'b1;
				tick();
				wr    = 1'b0;
			end
			K_READ: begin
				addr = ent.addr;
				rd   = 1'b1;
				tick();   // rd sampled
				rd   = 1'b0;
				tick();   // rdata loaded
				check_value($sformatf("rdata at %04h", ent.addr), rdata, ent.expected);
			end
			K_KEYS: joystick = ent.data[7:0];
			K_MODE: is_cgb = ent.data[0];
			K_RAISE: begin
				{timer_irq, lcd_irq, vblank_irq} = ent.data[2:0];
				tick();
				{timer_irq, lcd_irq, vblank_irq} = 3'b000;
			end
			K_ACK: begin
				check_value("irq_vector", irq_vector, ent.expected);
				// line is high exactly when the idle vector shows
				check_value("irq_n", {7'd0, irq_n}, (ent.expected == 8'h55) ? 8'h01 : 8'h00);
				irq_ack = 1'b1;
				{timer_irq, lcd_irq, vblank_irq} = ent.data[2:0];
				tick();
				irq_ack = 1'b0;
				{timer_irq, lcd_irq, vblank_irq} = 3'b000;
			end
			K_WAIT: begin
				repeat (ent.data) tick();
				check_value("irq_n", {7'd0, irq_n}, ent.expected);
			end
			default: begin
				$display("table entry has unknown kind %0d", ent.kind);
				$display(">>> FAIL");
				$fatal(1, "bad table entry");
			end
		endcase
	endtask

	task automatic build_table();
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b3;
		logic [7:0] b7;
		logic [7:0] bm;
		logic [7:0] h0;
		logic [7:0] h1;
		b0 = 8'($urandom());
		b1 = 8'($urandom());
		b3 = 8'($urandom());
		b7 = 8'($urandom());
		bm = 8'($urandom());
		h0 = 8'($urandom());
		h1 = 8'($urandom());

		// ------------------------------------------------------------
		// reset values, colour mode
		expect_read(16'hFF0F, 8'hE0);   // IF, top bits read 1
		expect_read(16'hFFFF, 8'h00);
		expect_read(16'hFF02, 8'h7E);
		expect_read(16'hFF70, 8'hF9);   // bank 1
		expect_read(16'hFF00, 8'hCF);   // both rows selected, no keys

		// ------------------------------------------------------------
		// work RAM banking
		queue_write(16'hFF70, 8'h01);
		queue_write(16'hD000, b1);
		queue_write(16'hFF70, 8'h03);
		queue_write(16'hD000, b3);
		queue_write(16'hFF70, 8'h07);
		queue_write(16'hD000, b7);
		queue_write(16'hC000, b0);      // fixed bank 0
		queue_write(16'hFF70, 8'h01);
		expect_read(16'hD000, b1);
		expect_read(16'hC000, b0);
		queue_write(16'hFF70, 8'h03);
		expect_read(16'hD000, b3);
		expect_read(16'hC000, b0);
		queue_write(16'hFF70, 8'h07);
		expect_read(16'hD000, b7);
		expect_read(16'hFF70, 8'hFF);
		queue_write(16'hFF70, 8'h00);   // 0 selects bank 1
		expect_read(16'hFF70, 8'hF9);
		expect_read(16'hD000, b1);

		// ------------------------------------------------------------
		// mono mode, open bus, high RAM
		queue_write(16'hFF70, 8'h07);
		add_entry(K_MODE, 16'h0000, 16'h0000, 8'h00);
		expect_read(16'hFF70, 8'hFF);   // SVBK hidden
		expect_read(16'hD000, b1);      // bank 1 despite SVBK = 7
		queue_write(16'hFF70, 8'h02);   // ignored in mono
		queue_write(16'hD000, bm);
		expect_read(16'hFF01, 8'hFF);
		expect_read(16'h8000, 8'hFF);
		expect_read(16'hE000, 8'hFF);
		expect_read(16'hFF50, 8'hFF);
		queue_write(16'hFF80, h0);
		queue_write(16'hFFFE, h1);
		expect_read(16'hFF80, h0);
		expect_read(16'hFFFE, h1);
		add_entry(K_MODE, 16'h0000, 16'h0001, 8'h00);
		expect_read(16'hFF70, 8'hFF);   // still bank 7
		expect_read(16'hD000, b7);
		queue_write(16'hFF70, 8'h01);
		expect_read(16'hD000, bm);      // mono write landed in bank 1

		// ------------------------------------------------------------
		// joypad matrix and press interrupt
		queue_write(16'hFFFF, 8'h10);
		queue_write(16'hFF0F, 8'h00);
		queue_write(16'hFF00, 8'h20);   // direction row
		add_entry(K_KEYS, 16'h0000, 16'h0001, 8'h00);
		add_entry(K_WAIT, 16'h0000, 16'd3, 8'h00);   // IF bit 4 within 3 cycles
		expect_read(16'hFF0F, 8'hF0);
		expect_read(16'hFF00, 8'hEE);
		queue_write(16'hFF00, 8'h10);   // button row
		add_entry(K_KEYS, 16'h0000, 16'h0081, 8'h00);
		expect_read(16'hFF00, 8'hD7);
		queue_write(16'hFF00, 8'h00);   // both rows ANDed
		expect_read(16'hFF00, 8'hC6);
		queue_write(16'hFF00, 8'h30);   // none selected
		expect_read(16'hFF00, 8'hFF);
		add_entry(K_KEYS, 16'h0000, 16'h0000, 8'h00);

		// ------------------------------------------------------------
		// priority vector and acknowledge
		queue_write(16'hFFFF, 8'h00);
		queue_write(16'hFF0F, 8'h00);
		queue_write(16'hFFFF, 8'h07);
		expect_read(16'hFFFF, 8'h07);
		add_entry(K_RAISE, 16'h0000, 16'h0007, 8'h00);
		add_entry(K_ACK, 16'h0000, 16'h0000, 8'h40);
		add_entry(K_ACK, 16'h0000, 16'h0000, 8'h48);
		add_entry(K_ACK, 16'h0000, 16'h0000, 8'h50);
		add_entry(K_ACK, 16'h0000, 16'h0000, 8'h55);   // idle ack
		add_entry(K_RAISE, 16'h0000, 16'h0001, 8'h00);
		add_entry(K_ACK, 16'h0000, 16'h0001, 8'h40);   // new vblank beats the ack
		add_entry(K_ACK, 16'h0000, 16'h0000, 8'h40);
		add_entry(K_ACK, 16'h0000, 16'h0000, 8'h55);
		expect_read(16'hFF0F, 8'hE0);

		// ------------------------------------------------------------
		// serial transfer, 8 x 512 + 1 cycles after the SC write edge
		queue_write(16'hFFFF, 8'h08);
		queue_write(16'hFF0F, 8'h00);
		queue_write(16'hFF02, 8'h81);
		expect_read(16'hFF02, 8'hFF);   // running
		// the read above used 2 of the cycles
		add_entry(K_WAIT, 16'h0000, 16'd4094, 8'h01);
		add_entry(K_WAIT, 16'h0000, 16'd1, 8'h00);
		expect_read(16'hFF02, 8'h7F);
		expect_read(16'hFF0F, 8'hE8);
	endtask

	initial begin
		reset      = 1'b1;
		is_cgb     = 1'b1;
		addr       = 16'h0000;
		wdata      = 8'h00;
		rd         = 1'b0;
		wr         = 1'b0;
		irq_ack    = 1'b0;
		joystick   = 8'h00;
		vblank_irq = 1'b0;
		lcd_irq    = 1'b0;
		timer_irq  = 1'b0;

		void'($urandom(32'hf533));
		build_table();
		cycle_limit = table_q.size() + 5000;

		repeat (4) @(posedge clk_cpu);
		#2;
		reset = 1'b0;

		check_value("rdata", rdata, 8'hFF);
		check_value("irq_n", {7'd0, irq_n}, 8'h01);
		check_value("irq_vector", irq_vector, 8'h55);

		for (int i = 0; i < table_q.size(); i++)
			run_entry(table_q[i]);

		if (err_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
source/gb_io_pkg.sv
source/io_bus_if.sv
source/bus_decoder.sv
source/interrupt_ctrl.sv
source/joypad.sv
source/serial_port.sv
source/internal_ram.sv
source/gb_io_top.sv
tests/gb_io_assertions.sv
tests/tb_gb_io.sv

// ==== run.sh ====
#!/bin/sh
# build and run the gb_io testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
	-f all.f \
	--top-module tb_gb_io \
	-o tb_gb_io

# tee keeps the log even when the simulation stops early
./obj_dir/tb_gb_io | tee sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi

if ! grep -q ">>> PASS" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi

echo "simulation passed"
